//--- source/lsb_pkg.sv
`default_nettype none

package lsb_pkg;

    typedef logic [31:0] word_t;     // register value or load result
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] imm_t;      // signed offset
    typedef logic [3:0]  rob_tag_t;  // 0 = no dependency
    typedef logic [3:0]  lsb_idx_t;  // queue slot
    typedef logic [4:0]  lsb_cnt_t;  // occupancy 0..16

    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } lsb_op_t;

    typedef enum logic [1:0] {
        st_empty,
        st_waiting,   // operand tag still pending
        st_ready,
        st_committed  // store released by commit
    } entry_state_t;

    localparam int LSB_DEPTH = 16;
    localparam int FULL_MARGIN = 3;  // free slots left when full rises

    localparam rob_tag_t NO_TAG = 4'd0;

endpackage

`default_nettype wire

//--- source/lsb_queue.sv
`timescale 1ns/1ps
`default_nettype none

module lsb_queue (
    input  wire                        clk_in,
    input  wire                        rst_in,
    input  wire                        dispatch_valid,
    input  wire lsb_pkg::lsb_op_t      dispatch_op,
    input  wire lsb_pkg::rob_tag_t     dispatch_tag,
    input  wire lsb_pkg::imm_t         dispatch_imm,
    input  wire lsb_pkg::word_t        rs1_val,
    input  wire lsb_pkg::rob_tag_t     rs1_tag,
    input  wire lsb_pkg::word_t        rs2_val,
    input  wire lsb_pkg::rob_tag_t     rs2_tag,
    input  wire                        wakeup_valid,
    input  wire lsb_pkg::rob_tag_t     wakeup_tag,
    input  wire lsb_pkg::word_t        wakeup_val,
    input  wire                        commit,
    input  wire                        flush,
    input  wire                        pop,
    output lsb_pkg::entry_state_t      head_state,
    output lsb_pkg::lsb_op_t           head_op,
    output lsb_pkg::rob_tag_t          head_tag,
    output lsb_pkg::word_t             head_base,
    output lsb_pkg::imm_t              head_imm,
    output lsb_pkg::word_t             head_data,
    output logic                       lsb_full
);

    import lsb_pkg::*;

    // per-entry storage
    entry_state_t q_state   [LSB_DEPTH];
    lsb_op_t      q_op      [LSB_DEPTH];
    rob_tag_t     q_tag     [LSB_DEPTH];
    imm_t         q_imm     [LSB_DEPTH];
    word_t        q_base    [LSB_DEPTH];  // rs1 value
    rob_tag_t     q_rs1_tag [LSB_DEPTH];
    word_t        q_data    [LSB_DEPTH];  // rs2 value
    rob_tag_t     q_rs2_tag [LSB_DEPTH];

    lsb_idx_t head;
    lsb_idx_t rear;
    lsb_idx_t commit_idx;
    lsb_cnt_t occ_cnt;
    lsb_cnt_t cmt_cnt;

    logic [LSB_DEPTH-1:0] rs1_hit;
    logic [LSB_DEPTH-1:0] rs2_hit;
    logic [LSB_DEPTH-1:0] wake_ready;
    logic                 d_rs1_hit;
    logic                 d_rs2_hit;
    logic                 do_dispatch;

    assign do_dispatch = dispatch_valid && !flush;

    // live entries are contiguous from head, committed ones lead
    always_comb begin
        occ_cnt = '0;
        cmt_cnt = '0;
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (q_state[i] != st_empty) begin
                occ_cnt = occ_cnt + 1'b1;
            end
            if (q_state[i] == st_committed) begin
                cmt_cnt = cmt_cnt + 1'b1;
            end
        end
    end

    assign rear       = head + occ_cnt[3:0];
    assign commit_idx = head + cmt_cnt[3:0];
    assign lsb_full   = occ_cnt >= lsb_cnt_t'(LSB_DEPTH - FULL_MARGIN);

    // wakeup match against waiting entries
    always_comb begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            rs1_hit[i] = wakeup_valid && q_state[i] == st_waiting &&
                         q_rs1_tag[i] != NO_TAG && q_rs1_tag[i] == wakeup_tag;
            rs2_hit[i] = wakeup_valid && q_state[i] == st_waiting &&
                         q_rs2_tag[i] != NO_TAG && q_rs2_tag[i] == wakeup_tag;
            wake_ready[i] = q_state[i] == st_waiting &&
                            (q_rs1_tag[i] == NO_TAG || rs1_hit[i]) &&
                            (q_rs2_tag[i] == NO_TAG || rs2_hit[i]);
        end
    end

    // same-cycle broadcast also covers the incoming entry
    assign d_rs1_hit = wakeup_valid && rs1_tag != NO_TAG && rs1_tag == wakeup_tag;
    assign d_rs2_hit = wakeup_valid && rs2_tag != NO_TAG && rs2_tag == wakeup_tag;

    // payload and operand tags
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            if (rs1_hit[i]) begin
                q_base[i]    <= wakeup_val;
                q_rs1_tag[i] <= NO_TAG;
            end
            if (rs2_hit[i]) begin
                q_data[i]    <= wakeup_val;
                q_rs2_tag[i] <= NO_TAG;
            end
        end
        if (do_dispatch) begin
            q_op[rear]      <= dispatch_op;
            q_tag[rear]     <= dispatch_tag;
            q_imm[rear]     <= dispatch_imm;
            q_base[rear]    <= d_rs1_hit ? wakeup_val : rs1_val;
            q_rs1_tag[rear] <= d_rs1_hit ? NO_TAG : rs1_tag;
            q_data[rear]    <= d_rs2_hit ? wakeup_val : rs2_val;
            q_rs2_tag[rear] <= d_rs2_hit ? NO_TAG : rs2_tag;
        end
    end

    // entry state and head pointer
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head <= '0;
            for (int i = 0; i < LSB_DEPTH; i++) begin
                q_state[i] <= st_empty;
            end
        end else begin
            for (int i = 0; i < LSB_DEPTH; i++) begin
                if (wake_ready[i]) begin
                    q_state[i] <= st_ready;
                end
            end
            if (do_dispatch) begin
                if ((rs1_tag == NO_TAG || d_rs1_hit) && (rs2_tag == NO_TAG || d_rs2_hit)) begin
                    q_state[rear] <= st_ready;
                end else begin
                    q_state[rear] <= st_waiting;
                end
            end
            if (pop) begin
                q_state[head] <= st_empty;
                head          <= head + 1'b1;
            end
            if (flush) begin
                // committed stores survive
                for (int i = 0; i < LSB_DEPTH; i++) begin
                    if (q_state[i] != st_committed) begin
                        q_state[i] <= st_empty;
                    end
                end
            end else if (commit) begin
                q_state[commit_idx] <= st_committed;
            end
        end
    end

    assign head_state = q_state[head];
    assign head_op    = q_op[head];
    assign head_tag   = q_tag[head];
    assign head_base  = q_base[head];
    assign head_imm   = q_imm[head];
    assign head_data  = q_data[head];

endmodule

`default_nettype wire

//--- source/lsb_mem_seq.sv
`timescale 1ns/1ps
`default_nettype none

module lsb_mem_seq (
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire                         flush,
    input  wire lsb_pkg::entry_state_t  head_state,
    input  wire lsb_pkg::lsb_op_t       head_op,
    input  wire lsb_pkg::rob_tag_t      head_tag,
    input  wire lsb_pkg::word_t         head_base,
    input  wire lsb_pkg::imm_t          head_imm,
    input  wire lsb_pkg::word_t         head_data,
    input  wire lsb_pkg::byte_t         mem_byte,
    output logic                        mem_req,
    output logic                        mem_wr,
    output lsb_pkg::addr_t              mem_addr,
    output lsb_pkg::byte_t              mem_wdata,
    output logic                        pop,
    output logic                        result_valid,
    output lsb_pkg::rob_tag_t           result_tag,
    output lsb_pkg::word_t              result_data
);

    import lsb_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_load_run,
        s_store_run
    } seq_state_t;

    seq_state_t  seq_state;
    logic [2:0]  req_cnt;    // bytes requested so far
    logic [1:0]  rcv_cnt;    // bytes received so far
    logic        rd_due;     // read issued last cycle, byte arrives now
    logic [2:0]  nbytes;
    logic [1:0]  last_idx;
    logic        is_load;
    logic        start_load;
    logic        start_store;
    logic        last_byte;
    addr_t       start_addr;
    word_t       collect;
    word_t       load_word;

    function automatic logic [2:0] op_bytes(lsb_op_t op);
        case (op)
            op_lh, op_lhu, op_sh: return 3'd2;
            op_lw, op_sw:         return 3'd4;
            default:              return 3'd1;
        endcase
    endfunction

    function automatic word_t extend_load(lsb_op_t op, word_t raw);
        case (op)
            op_lb:   return {{24{raw[7]}}, raw[7:0]};
            op_lh:   return {{16{raw[15]}}, raw[15:0]};
            op_lbu:  return {24'd0, raw[7:0]};
            op_lhu:  return {16'd0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    assign nbytes     = op_bytes(head_op);
    assign last_idx   = 2'(nbytes - 3'd1);
    assign is_load    = head_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign start_addr = head_base + {{20{head_imm[11]}}, head_imm};

    // pop is still high while the head pointer catches up
    assign start_load  = head_state == st_ready && is_load && !pop && !flush;
    assign start_store = head_state == st_committed && !pop;

    assign last_byte = seq_state == s_load_run && rd_due && rcv_cnt == last_idx;

    // little-endian, incoming byte merged in place
    always_comb begin
        load_word = collect;
        load_word[8*rcv_cnt +: 8] = mem_byte;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            seq_state    <= s_idle;
            mem_req      <= 1'b0;
            mem_wr       <= 1'b0;
            pop          <= 1'b0;
            result_valid <= 1'b0;
            rd_due       <= 1'b0;
            req_cnt      <= '0;
            rcv_cnt      <= '0;
        end else begin
            pop          <= 1'b0;
            result_valid <= 1'b0;
            rd_due       <= mem_req && !mem_wr;
            case (seq_state)
                s_idle: begin
                    if (start_store) begin
                        seq_state <= s_store_run;
                        mem_req   <= 1'b1;
                        mem_wr    <= 1'b1;
                        req_cnt   <= 3'd1;
                    end else if (start_load) begin
                        seq_state <= s_load_run;
                        mem_req   <= 1'b1;
                        mem_wr    <= 1'b0;
                        req_cnt   <= 3'd1;
                        rcv_cnt   <= '0;
                    end
                end
                s_load_run: begin
                    if (flush) begin
                        seq_state <= s_idle; // load dropped, no result
                        mem_req   <= 1'b0;
                    end else begin
                        if (req_cnt != nbytes) begin
                            req_cnt <= req_cnt + 1'b1;
                        end else begin
                            mem_req <= 1'b0;
                        end
                        if (last_byte) begin
                            result_valid <= 1'b1;
                            pop          <= 1'b1;
                            seq_state    <= s_idle;
                        end else if (rd_due) begin
                            rcv_cnt <= rcv_cnt + 1'b1;
                        end
                    end
                end
                s_store_run: begin
                    // committed, so flush does not stop it
                    if (req_cnt != nbytes) begin
                        req_cnt <= req_cnt + 1'b1;
                    end else begin
                        mem_req   <= 1'b0;
                        mem_wr    <= 1'b0;
                        pop       <= 1'b1;
                        seq_state <= s_idle;
                    end
                end
                default: seq_state <= s_idle;
            endcase
        end
    end

    // address, write data and load result
    always_ff @(posedge clk_in) begin
        case (seq_state)
            s_idle: begin
                mem_addr  <= start_addr;
                mem_wdata <= head_data[7:0];
            end
            s_load_run, s_store_run: begin
                if (req_cnt != nbytes) begin
                    mem_addr  <= mem_addr + 1'b1;
                    mem_wdata <= head_data[8*req_cnt[1:0] +: 8];
                end
            end
            default: ;
        endcase
        if (rd_due) begin
            collect[8*rcv_cnt +: 8] <= mem_byte;
        end
        if (last_byte) begin
            result_tag  <= head_tag;
            result_data <= extend_load(head_op, load_word);
        end
    end

endmodule

`default_nettype wire

//--- source/lsb_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsb_top (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      dispatch_valid,
    input  wire lsb_pkg::lsb_op_t    dispatch_op,
    input  wire lsb_pkg::rob_tag_t   dispatch_tag,
    input  wire lsb_pkg::imm_t       dispatch_imm,
    input  wire lsb_pkg::word_t      rs1_val,
    input  wire lsb_pkg::rob_tag_t   rs1_tag,
    input  wire lsb_pkg::word_t      rs2_val,
    input  wire lsb_pkg::rob_tag_t   rs2_tag,
    input  wire                      wakeup_valid,
    input  wire lsb_pkg::rob_tag_t   wakeup_tag,
    input  wire lsb_pkg::word_t      wakeup_val,
    input  wire                      commit,
    input  wire                      flush,
    input  wire lsb_pkg::byte_t      mem_byte,
    output wire                      mem_req,
    output wire                      mem_wr,
    output wire lsb_pkg::addr_t      mem_addr,
    output wire lsb_pkg::byte_t      mem_wdata,
    output wire                      lsb_full,
    output wire                      result_valid,
    output wire lsb_pkg::rob_tag_t   result_tag,
    output wire lsb_pkg::word_t      result_data
);

    import lsb_pkg::*;

    // head entry as seen by the sequencer
    entry_state_t head_state;
    lsb_op_t      head_op;
    rob_tag_t     head_tag;
    word_t        head_base;
    imm_t         head_imm;
    word_t        head_data;
    logic         pop;

    lsb_queue u_queue (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .dispatch_imm   (dispatch_imm),
        .rs1_val        (rs1_val),
        .rs1_tag        (rs1_tag),
        .rs2_val        (rs2_val),
        .rs2_tag        (rs2_tag),
        .wakeup_valid   (wakeup_valid),
        .wakeup_tag     (wakeup_tag),
        .wakeup_val     (wakeup_val),
        .commit         (commit),
        .flush          (flush),
        .pop            (pop),
        .head_state     (head_state),
        .head_op        (head_op),
        .head_tag       (head_tag),
        .head_base      (head_base),
        .head_imm       (head_imm),
        .head_data      (head_data),
        .lsb_full       (lsb_full)
    );

    lsb_mem_seq u_seq (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .flush        (flush),
        .head_state   (head_state),
        .head_op      (head_op),
        .head_tag     (head_tag),
        .head_base    (head_base),
        .head_imm     (head_imm),
        .head_data    (head_data),
        .mem_byte     (mem_byte),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .pop          (pop),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

//--- testbench/lsb_assert.sv
`timescale 1ns/1ps
`default_nettype none

module lsb_assert (
    input wire                    clk_in,
    input wire                    rst_in,
    input wire                    mem_req,
    input wire                    mem_wr,
    input wire                    result_valid,
    input wire lsb_pkg::rob_tag_t result_tag
);

    import lsb_pkg::*;

    wr_needs_req: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_wr |-> mem_req)
        else $error("mem_wr high without mem_req");

    result_has_tag: assert property (@(posedge clk_in) disable iff (rst_in)
        result_valid |-> result_tag != NO_TAG)
        else $error("result_valid with a zero result_tag");

    // outputs settle one edge into reset
    quiet_in_reset: assert property (@(posedge clk_in)
        $past(rst_in) |-> !mem_req && !mem_wr && !result_valid)
        else $error("memory or result strobe active during reset");

endmodule

bind lsb_top lsb_assert u_assert (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .mem_req      (mem_req),
    .mem_wr       (mem_wr),
    .result_valid (result_valid),
    .result_tag   (result_tag)
);

`default_nettype wire

//--- testbench/tb_lsb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsb;

    import lsb_pkg::*;

    localparam int MEM_SIZE   = 256;
    localparam int MAX_TESTS  = 64;
    localparam int FILL_COUNT = 13;          // 16 slots, 3 kept free
    localparam rob_tag_t SRC_TAG = 4'd15;    // producer of pending operands

    logic     clk_in;
    logic     rst_in;
    logic     dispatch_valid;
    lsb_op_t  dispatch_op;
    rob_tag_t dispatch_tag;
    imm_t     dispatch_imm;
    word_t    rs1_val;
    rob_tag_t rs1_tag;
    word_t    rs2_val;
    rob_tag_t rs2_tag;
    logic     wakeup_valid;
    rob_tag_t wakeup_tag;
    word_t    wakeup_val;
    logic     commit;
    logic     flush;
    byte_t    mem_byte;
    logic     mem_req;
    logic     mem_wr;
    addr_t    mem_addr;
    byte_t    mem_wdata;
    logic     lsb_full;
    logic     result_valid;
    rob_tag_t result_tag;
    word_t    result_data;

    byte_t    mem [MEM_SIZE];
    logic     rd_pend;
    logic [7:0] rd_addr;
    rob_tag_t res_tag_q [$];
    word_t    res_data_q [$];
    addr_t    wr_addr_q [$];
    byte_t    wr_data_q [$];

    // golden table
    logic [127:0] t_name [MAX_TESTS];
    lsb_op_t      t_op   [MAX_TESTS];
    rob_tag_t     t_tag  [MAX_TESTS];
    word_t        t_rs1  [MAX_TESTS];
    imm_t         t_imm  [MAX_TESTS];
    word_t        t_rs2  [MAX_TESTS];
    logic [3:0]   t_pend [MAX_TESTS];
    logic [63:0]  t_act  [MAX_TESTS];
    word_t        t_exp  [MAX_TESTS];

    int     n_tests;
    int     err_cnt;
    int     pass_cnt;
    integer seed;
    logic   loaded;

    lsb_top u_lsb_top (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .dispatch_imm   (dispatch_imm),
        .rs1_val        (rs1_val),
        .rs1_tag        (rs1_tag),
        .rs2_val        (rs2_val),
        .rs2_tag        (rs2_tag),
        .wakeup_valid   (wakeup_valid),
        .wakeup_tag     (wakeup_tag),
        .wakeup_val     (wakeup_val),
        .commit         (commit),
        .flush          (flush),
        .mem_byte       (mem_byte),
        .mem_req        (mem_req),
        .mem_wr         (mem_wr),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .lsb_full       (lsb_full),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_data    (result_data)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a] = byte_t'(a * 7 + 3);
        end
    end

    // request seen mid-cycle, read byte driven just after the next edge
    always begin
        @(negedge clk_in);
        rd_pend = mem_req === 1'b1 && mem_wr === 1'b0;
        rd_addr = mem_addr[7:0];
        if (mem_req === 1'b1 && mem_wr === 1'b1) begin
            mem[mem_addr[7:0]] = mem_wdata;
            wr_addr_q.push_back(mem_addr);
            wr_data_q.push_back(mem_wdata);
        end
        @(posedge clk_in);
        #1;
        if (rd_pend) begin
            mem_byte = mem[rd_addr];
        end
    end

    always @(negedge clk_in) begin
        if (result_valid === 1'b1) begin
            res_tag_q.push_back(result_tag);
            res_data_q.push_back(result_data);
        end
    end

    task automatic check_word(input logic [127:0] name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %0s word expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_tag(input logic [127:0] name, input rob_tag_t exp, input rob_tag_t act);
        if (exp !== act) begin
            $display("ERR %0s tag expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input logic [127:0] name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("ERR %0s address expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_problem(input logic [127:0] name, input string what);
        $display("%0s: %0s", name, what);
        err_cnt++;
    endtask

    function automatic lsb_op_t op_from_text(input logic [63:0] txt);
        case (txt)
            "lh":    return op_lh;
            "lw":    return op_lw;
            "lbu":   return op_lbu;
            "lhu":   return op_lhu;
            "sb":    return op_sb;
            "sh":    return op_sh;
            "sw":    return op_sw;
            default: return op_lb;
        endcase
    endfunction

    // bytes written by a store, 0 for loads
    function automatic int store_width(input lsb_op_t op);
        case (op)
            op_sb:   return 1;
            op_sh:   return 2;
            op_sw:   return 4;
            default: return 0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic load_golden();
        integer       fd;
        integer       rc;
        logic [1023:0] line;
        logic [127:0] nm;
        logic [63:0]  op_txt;
        logic [63:0]  act_txt;
        rob_tag_t     tag_v;
        word_t        rs1_v;
        imm_t         imm_v;
        word_t        rs2_v;
        logic [3:0]   pend_v;
        word_t        exp_v;
        fd = $fopen("testbench/lsb_golden.txt", "r");
        if (fd == 0) begin
            report_problem("golden", "cannot open the golden file");
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = '0;
                rc = $fgets(line, fd);
                // comment lines fail the hex fields and are skipped
                if (rc != 0 &&
                    $sscanf(line, "%s %s %h %h %h %h %h %s %h", nm, op_txt, tag_v, rs1_v,
                            imm_v, rs2_v, pend_v, act_txt, exp_v) == 9) begin
                    t_name[n_tests] = nm;
                    t_op[n_tests]   = op_from_text(op_txt);
                    t_tag[n_tests]  = tag_v;
                    t_rs1[n_tests]  = rs1_v;
                    t_imm[n_tests]  = imm_v;
                    t_rs2[n_tests]  = rs2_v;
                    t_pend[n_tests] = pend_v;
                    t_act[n_tests]  = act_txt;
                    t_exp[n_tests]  = exp_v;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic dispatch_entry(input int i, input logic pending, input rob_tag_t tag);
        dispatch_valid = 1'b1;
        dispatch_op    = t_op[i];
        dispatch_tag   = tag;
        dispatch_imm   = t_imm[i];
        rs1_val        = pending ? 32'hdead_0000 : t_rs1[i]; // junk until wakeup
        rs1_tag        = pending ? SRC_TAG : NO_TAG;
        rs2_val        = t_rs2[i];
        rs2_tag        = NO_TAG;
        next_cycle();
        dispatch_valid = 1'b0;
    endtask

    task automatic send_wakeup(input word_t val);
        wakeup_valid = 1'b1;
        wakeup_tag   = SRC_TAG;
        wakeup_val   = val;
        next_cycle();
        wakeup_valid = 1'b0;
    endtask

    task automatic expect_result(input int i, input rob_tag_t tag);
        int waited;
        waited = 0;
        while (res_tag_q.size() == 0 && waited < 100) begin
            next_cycle();
            waited++;
        end
        if (res_tag_q.size() == 0) begin
            report_problem(t_name[i], "load gave no result");
        end else begin
            check_tag(t_name[i], tag, res_tag_q.pop_front());
            check_word(t_name[i], t_exp[i], res_data_q.pop_front());
        end
    endtask

    task automatic expect_writes(input int i);
        int    n;
        int    waited;
        word_t got;
        addr_t base;
        n      = store_width(t_op[i]);
        base   = t_rs1[i] + {{20{t_imm[i][11]}}, t_imm[i]};
        got    = '0;
        waited = 0;
        while (wr_addr_q.size() < n && waited < 100) begin
            next_cycle();
            waited++;
        end
        if (wr_addr_q.size() < n) begin
            report_problem(t_name[i], "store wrote fewer bytes than its width");
        end else begin
            for (int b = 0; b < n; b++) begin
                check_addr(t_name[i], addr_t'(base + b), wr_addr_q.pop_front());
                got[8*b +: 8] = wr_data_q.pop_front();
            end
            check_word(t_name[i], t_exp[i], got);
        end
    endtask

    task automatic fill_and_drain(input int i);
        rob_tag_t tag;
        for (int k = 0; k < FILL_COUNT; k++) begin
            if (lsb_full !== 1'b0) begin
                report_problem(t_name[i], "lsb_full high before the buffer filled");
            end
            // distinct tags from the golden one, so the drain order shows
            tag = rob_tag_t'((t_tag[i] + k - 1) % 15 + 1);
            dispatch_entry(i, 1'b1, tag);
        end
        if (lsb_full !== 1'b1) begin
            report_problem(t_name[i], "lsb_full low with 13 entries held");
        end
        send_wakeup(t_rs1[i]);
        for (int k = 0; k < FILL_COUNT; k++) begin
            tag = rob_tag_t'((t_tag[i] + k - 1) % 15 + 1);
            expect_result(i, tag);
        end
        next_cycle();
        if (lsb_full !== 1'b0) begin
            report_problem(t_name[i], "lsb_full still high after draining");
        end
    endtask

    task automatic run_test(input int i);
        int   errs_before;
        int   gap;
        logic pending;
        logic is_store;
        errs_before = err_cnt;
        pending     = t_pend[i][0];
        is_store    = store_width(t_op[i]) != 0;
        gap         = 1 + int'($unsigned($random(seed)) % 4);
        repeat (gap) next_cycle();
        if (t_act[i] == "fill") begin
            fill_and_drain(i);
        end else if (t_act[i] == "flush" && !is_store) begin
            dispatch_entry(i, pending, t_tag[i]);
            next_cycle(); // ready load is in flight by now
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            if (pending) begin
                send_wakeup(t_rs1[i]);
            end
        end else begin
            dispatch_entry(i, pending, t_tag[i]);
            repeat (gap + 8) next_cycle(); // longer than one full access
            if (pending) begin
                if (res_tag_q.size() != 0) begin
                    report_problem(t_name[i], "result arrived before wakeup");
                end
                send_wakeup(t_rs1[i]);
            end
            if (is_store) begin
                if (wr_addr_q.size() != 0) begin
                    report_problem(t_name[i], "memory written before commit");
                end
                commit = 1'b1;
                next_cycle();
                commit = 1'b0;
                if (t_act[i] == "flush") begin
                    flush = 1'b1;
                    next_cycle();
                    flush = 1'b0;
                end
                expect_writes(i);
            end else begin
                expect_result(i, t_tag[i]);
            end
        end
        repeat (20) next_cycle();
        if (res_tag_q.size() != 0) begin
            report_problem(t_name[i], "unexpected load result");
        end
        if (wr_addr_q.size() != 0) begin
            report_problem(t_name[i], "unexpected memory write");
        end
        res_tag_q.delete();
        res_data_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0s passed", t_name[i]);
        end else begin
            $display("test %0s failed", t_name[i]);
        end
    endtask

    initial begin
        rst_in         = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = op_lb;
        dispatch_tag   = NO_TAG;
        dispatch_imm   = '0;
        rs1_val        = '0;
        rs1_tag        = NO_TAG;
        rs2_val        = '0;
        rs2_tag        = NO_TAG;
        wakeup_valid   = 1'b0;
        wakeup_tag     = NO_TAG;
        wakeup_val     = '0;
        commit         = 1'b0;
        flush          = 1'b0;
        mem_byte       = '0;
        seed           = 32'h2879;
        n_tests        = 0;
        err_cnt        = 0;
        pass_cnt       = 0;
        loaded         = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (10) next_cycle();
        rst_in = 1'b0;
        if (mem_req !== 1'b0 || result_valid !== 1'b0 || lsb_full !== 1'b0) begin
            report_problem("reset", "outputs not low after reset");
        end
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("%0d tests, %0d passed, %0d error count", n_tests, pass_cnt, err_cnt);
        if (err_cnt == 0 && n_tests > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // run limit scales with the golden table
    initial begin
        wait (loaded === 1'b1);
        repeat (200 * (n_tests + 1)) @(posedge clk_in);
        $display("timeout, the tests did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- lsb_top.f
source/lsb_pkg.sv
source/lsb_queue.sv
source/lsb_mem_seq.sv
source/lsb_top.sv
testbench/lsb_assert.sv
testbench/tb_lsb.sv

//--- testbench/lsb_golden.txt
# name op tag rs1 imm rs2 pend action expect
# all numbers hex, imm is a 12-bit signed offset, expect is the load result or stored bytes
lb_neg      lb   1 00000010 005 00000000 0 none   ffffff96
lbu_zero    lbu  2 00000010 005 00000000 0 none   00000096
lh_neg      lh   3 00000020 ffc 00000000 0 none   ffffcec7
lhu_zero    lhu  4 00000020 ffc 00000000 0 none   0000cec7
lw_plain    lw   5 00000040 000 00000000 0 none   d8d1cac3
lh_pos      lh   6 00000000 002 00000000 0 none   00001811
lw_wake     lw   7 00000080 004 00000000 1 none   b4ada69f
lbu_wake    lbu  8 00000030 001 00000000 1 none   0000005a
sw_commit   sw   9 000000a0 008 12345678 0 commit 12345678
lw_after_sw lw   a 000000a0 008 00000000 0 none   12345678
sb_commit   sb   b 000000a8 001 cafe00ee 0 commit 000000ee
lw_after_sb lw   c 000000a8 000 00000000 0 none   1234ee78
sh_flush    sh   d 000000c0 002 0000beef 0 flush  0000beef
lh_after_sh lh   e 000000c0 002 00000000 0 none   ffffbeef
lw_flushed  lw   1 00000040 000 00000000 0 flush  00000000
lb_flush_wt lb   2 00000010 005 00000000 1 flush  00000000
lw_fill     lw   3 00000040 000 00000000 1 fill   d8d1cac3
lb_resume   lb   4 00000000 002 00000000 0 none   00000011
